/* logic/matmul_cfg.svh */
`ifndef MATMUL_CFG_SVH
`define MATMUL_CFG_SVH

// Element, address and stride widths
`define MM_DWIDTH       8
`define MM_AWIDTH       10
`define MM_STRIDE_WIDTH 16

// Matrix dimension N
`define MM_SIZE         4

// Holds N products of two full-scale elements
`define MM_ACC_WIDTH    20

// Address to data at the operand memories
`define MM_MEM_LATENCY  1

`endif

/* logic/matmul_pkg.sv */
`default_nettype none

`include "matmul_cfg.svh"

package matmul_pkg;

  typedef logic [`MM_DWIDTH-1:0]          data_t;
  typedef logic [`MM_AWIDTH-1:0]          addr_t;
  typedef logic [`MM_STRIDE_WIDTH-1:0]    stride_t;
  typedef logic [`MM_ACC_WIDTH-1:0]       acc_t;

  // Lane i sits at bits [i*DWIDTH +: DWIDTH]
  typedef logic [`MM_SIZE*`MM_DWIDTH-1:0] lane_vec_t;

  typedef struct packed {
    addr_t   addr_a;
    addr_t   addr_b;
    addr_t   addr_c;
    stride_t stride_a;
    stride_t stride_b;
    stride_t stride_c;
  } matmul_cmd_t;

  typedef struct packed {
    logic      available;
    addr_t     addr;
    lane_vec_t data;
  } c_row_t;

  typedef enum logic [2:0] {
    st_idle,
    st_feed,
    st_drain,
    st_write,
    st_done
  } ctrl_state_t;

endpackage

`default_nettype wire

/* logic/matmul_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_cfg.svh"

module matmul_ctrl (
  input  wire  clk,
  input  wire  reset,
  input  wire  start_mat_mul,
  output logic feed_en,
  output logic clear_acc,
  output logic write_en,
  output logic done_mat_mul
);

  localparam int FEED_LEN  = `MM_SIZE;
  // Memory latency, then N-1 cycles of lane skew and N-1 hops across the array
  localparam int DRAIN_LEN = `MM_MEM_LATENCY + 2 * (`MM_SIZE - 1);
  localparam int WRITE_LEN = `MM_SIZE;
  localparam int CNT_W     = $clog2(DRAIN_LEN + 1);

  matmul_pkg::ctrl_state_t state;
  logic [CNT_W-1:0]        step;

  assign feed_en  = (state == matmul_pkg::st_feed);
  assign write_en = (state == matmul_pkg::st_write);

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= matmul_pkg::st_idle;
      step         <= '0;
      clear_acc    <= 1'b0;
      done_mat_mul <= 1'b0;
    end else begin
      clear_acc    <= 1'b0;
      // Lands one cycle after the last C row is on c_out
      done_mat_mul <= (state == matmul_pkg::st_done);
      case (state)
        matmul_pkg::st_idle: begin
          if (start_mat_mul) begin
            state     <= matmul_pkg::st_feed;
            step      <= CNT_W'(FEED_LEN - 1);
            clear_acc <= 1'b1;
          end
        end
        matmul_pkg::st_feed: begin
          if (step == '0) begin
            state <= matmul_pkg::st_drain;
            step  <= CNT_W'(DRAIN_LEN - 1);
          end else begin
            step <= step - 1'b1;
          end
        end
        matmul_pkg::st_drain: begin
          if (step == '0) begin
            state <= matmul_pkg::st_write;
            step  <= CNT_W'(WRITE_LEN - 1);
          end else begin
            step <= step - 1'b1;
          end
        end
        matmul_pkg::st_write: begin
          if (step == '0) begin
            state <= matmul_pkg::st_done;
          end else begin
            step <= step - 1'b1;
          end
        end
        matmul_pkg::st_done: begin
          state <= matmul_pkg::st_idle;
        end
        default: begin
          state <= matmul_pkg::st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/operand_feeder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_cfg.svh"

module operand_feeder (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        feed_en,
  input  wire matmul_pkg::addr_t     base,
  input  wire matmul_pkg::stride_t   stride,
  output matmul_pkg::addr_t          mem_addr,
  input  wire matmul_pkg::lane_vec_t mem_data,
  output matmul_pkg::lane_vec_t      lanes
);

  localparam int N   = `MM_SIZE;
  localparam int DW  = `MM_DWIDTH;
  localparam int LAT = `MM_MEM_LATENCY;

  matmul_pkg::addr_t     addr_q;
  logic [LAT-1:0]        feed_dly;
  logic                  first_step;
  logic                  data_valid;
  matmul_pkg::lane_vec_t word;
  matmul_pkg::data_t     lane_out [N];

  // feed_dly[0] is feed_en one cycle back
  assign first_step = feed_en && !feed_dly[0];
  assign mem_addr   = first_step ? base : addr_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      addr_q   <= '0;
      feed_dly <= '0;
    end else begin
      if (feed_en) begin
        addr_q <= mem_addr + matmul_pkg::addr_t'(stride);
      end
      feed_dly[0] <= feed_en;
      for (int s = 1; s < LAT; s++) begin
        feed_dly[s] <= feed_dly[s-1];
      end
    end
  end

  assign data_valid = feed_dly[LAT-1];
  assign word       = data_valid ? mem_data : '0;

  // Lane i is held back i cycles to form the diagonal wavefront
  genvar i;
  generate
    for (i = 0; i < N; i++) begin : g_lane
      if (i == 0) begin : g_direct
        assign lane_out[i] = word[i*DW +: DW];
      end else begin : g_skew
        matmul_pkg::data_t dly [i];
        always_ff @(posedge clk) begin
          if (reset) begin
            for (int s = 0; s < i; s++) begin
              dly[s] <= '0;
            end
          end else begin
            dly[0] <= word[i*DW +: DW];
            for (int s = 1; s < i; s++) begin
              dly[s] <= dly[s-1];
            end
          end
        end
        assign lane_out[i] = dly[i-1];
      end
    end
  endgenerate

  always_comb begin
    for (int k = 0; k < N; k++) begin
      lanes[k*DW +: DW] = lane_out[k];
    end
  end

endmodule

`default_nettype wire

/* logic/systolic_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_cfg.svh"

module systolic_array (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        clear_acc,
  input  wire matmul_pkg::lane_vec_t a_lanes,
  input  wire matmul_pkg::lane_vec_t b_lanes,
  output matmul_pkg::acc_t [`MM_SIZE-1:0][`MM_SIZE-1:0] acc_grid
);

  localparam int N  = `MM_SIZE;
  localparam int DW = `MM_DWIDTH;

  matmul_pkg::data_t a_q   [N][N];
  matmul_pkg::data_t b_q   [N][N];
  matmul_pkg::acc_t  acc_q [N][N];

  ////////////////////
  // MAC grid, cell (i, j) builds C[i][j]
  ////////////////////

  genvar i, j;
  generate
    for (i = 0; i < N; i++) begin : g_row
      for (j = 0; j < N; j++) begin : g_col
        matmul_pkg::data_t a_in;
        matmul_pkg::data_t b_in;

        // Edge cells take the skewed lanes
        if (j == 0) begin : g_a_edge
          assign a_in = a_lanes[i*DW +: DW];
        end else begin : g_a_fwd
          assign a_in = a_q[i][j-1];
        end

        if (i == 0) begin : g_b_edge
          assign b_in = b_lanes[j*DW +: DW];
        end else begin : g_b_fwd
          assign b_in = b_q[i-1][j];
        end

        always_ff @(posedge clk) begin
          if (reset || clear_acc) begin
            a_q[i][j]   <= '0;
            b_q[i][j]   <= '0;
            acc_q[i][j] <= '0;
          end else begin
            a_q[i][j]   <= a_in;
            b_q[i][j]   <= b_in;
            acc_q[i][j] <= acc_q[i][j] + a_in * b_in;
          end
        end
      end
    end
  endgenerate

  always_comb begin
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        acc_grid[r][c] = acc_q[r][c];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/result_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_cfg.svh"

module result_writer (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      write_en,
  input  wire matmul_pkg::addr_t   base,
  input  wire matmul_pkg::stride_t stride,
  input  wire matmul_pkg::acc_t [`MM_SIZE-1:0][`MM_SIZE-1:0] acc_grid,
  output matmul_pkg::c_row_t       c_out
);

  localparam int N     = `MM_SIZE;
  localparam int DW    = `MM_DWIDTH;
  localparam int ROW_W = $clog2(N);

  logic [ROW_W-1:0]      row_idx;
  matmul_pkg::addr_t     addr_q;
  matmul_pkg::addr_t     row_addr;
  matmul_pkg::lane_vec_t row_data;
  logic                  avail_q;
  matmul_pkg::addr_t     out_addr_q;
  matmul_pkg::lane_vec_t out_data_q;

  // Row 0 goes straight to the C base
  assign row_addr = (row_idx == '0) ? base : addr_q;

  // Low byte of each accumulator
  always_comb begin
    for (int j = 0; j < N; j++) begin
      row_data[j*DW +: DW] = acc_grid[row_idx][j][DW-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      avail_q <= 1'b0;
      row_idx <= '0;
      addr_q  <= '0;
    end else begin
      avail_q <= write_en;
      if (write_en) begin
        row_idx <= row_idx + 1'b1;
        addr_q  <= row_addr + matmul_pkg::addr_t'(stride);
      end else begin
        row_idx <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      out_addr_q <= row_addr;
      out_data_q <= row_data;
    end
  end

  assign c_out = '{available: avail_q, addr: out_addr_q, data: out_data_q};

endmodule

`default_nettype wire

/* logic/matmul_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_cfg.svh"

module matmul_top (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          start_mat_mul,
  input  wire matmul_pkg::matmul_cmd_t cmd,
  output matmul_pkg::addr_t            a_addr,
  output matmul_pkg::addr_t            b_addr,
  input  wire matmul_pkg::lane_vec_t   a_data,
  input  wire matmul_pkg::lane_vec_t   b_data,
  output matmul_pkg::c_row_t           c_out,
  output logic                         done_mat_mul
);

  logic                  feed_en;
  logic                  clear_acc;
  logic                  write_en;
  matmul_pkg::lane_vec_t a_lanes;
  matmul_pkg::lane_vec_t b_lanes;
  matmul_pkg::acc_t [`MM_SIZE-1:0][`MM_SIZE-1:0] acc_grid;

  matmul_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .start_mat_mul(start_mat_mul),
    .feed_en      (feed_en),
    .clear_acc    (clear_acc),
    .write_en     (write_en),
    .done_mat_mul (done_mat_mul)
  );

  ////////////////////
  // Operand feeders, A enters from the left and B from the top
  ////////////////////

  operand_feeder u_feed_a (
    .clk     (clk),
    .reset   (reset),
    .feed_en (feed_en),
    .base    (cmd.addr_a),
    .stride  (cmd.stride_a),
    .mem_addr(a_addr),
    .mem_data(a_data),
    .lanes   (a_lanes)
  );

  operand_feeder u_feed_b (
    .clk     (clk),
    .reset   (reset),
    .feed_en (feed_en),
    .base    (cmd.addr_b),
    .stride  (cmd.stride_b),
    .mem_addr(b_addr),
    .mem_data(b_data),
    .lanes   (b_lanes)
  );

  systolic_array u_array (
    .clk      (clk),
    .reset    (reset),
    .clear_acc(clear_acc),
    .a_lanes  (a_lanes),
    .b_lanes  (b_lanes),
    .acc_grid (acc_grid)
  );

  result_writer u_writer (
    .clk     (clk),
    .reset   (reset),
    .write_en(write_en),
    .base    (cmd.addr_c),
    .stride  (cmd.stride_c),
    .acc_grid(acc_grid),
    .c_out   (c_out)
  );

endmodule

`default_nettype wire

/* tests/matmul_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_cfg.svh"

module matmul_checker (
  input wire clk,
  input wire reset,
  input wire feed_en,
  input wire clear_acc,
  input wire write_en,
  input wire done_mat_mul
);

  localparam int N = `MM_SIZE;

  int fail_count = 0;

  // Write window opens only after the drain gap behind the feed window
  a_phase_excl: assert property (@(posedge clk) disable iff (reset)
    $rose(write_en) |-> (!$past(feed_en, 2 * N - 1) && $past(feed_en, 2 * N))
  ) else begin
    $error("write_en window not separated from feed_en by the drain phase");
    fail_count++;
  end

  // A feed window opens together with the accumulator clear
  a_feed_clear: assert property (@(posedge clk) disable iff (reset)
    $rose(feed_en) |-> clear_acc
  ) else begin
    $error("feed_en rose without clear_acc");
    fail_count++;
  end

  // One write window of exactly N cycles
  a_write_len: assert property (@(posedge clk) disable iff (reset)
    $fell(write_en) |-> ($past(write_en, N) && !$past(write_en, N + 1))
  ) else begin
    $error("write_en window is not %0d cycles long", N);
    fail_count++;
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (reset)
    done_mat_mul |=> !done_mat_mul
  ) else begin
    $error("done_mat_mul high for more than one cycle");
    fail_count++;
  end

  // Done lands one cycle after the last C row leaves the writer
  a_done_after_write: assert property (@(posedge clk) disable iff (reset)
    $fell(write_en) |=> done_mat_mul
  ) else begin
    $error("done_mat_mul missing after the write window");
    fail_count++;
  end

  a_done_has_write: assert property (@(posedge clk) disable iff (reset)
    done_mat_mul |-> $past(write_en, 2)
  ) else begin
    $error("done_mat_mul without a preceding write window");
    fail_count++;
  end

endmodule

bind matmul_ctrl matmul_checker u_checker (
  .clk         (clk),
  .reset       (reset),
  .feed_en     (feed_en),
  .clear_acc   (clear_acc),
  .write_en    (write_en),
  .done_mat_mul(done_mat_mul)
);

`default_nettype wire

/* tests/matmul_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_cfg.svh"

module matmul_tb;

  localparam int N               = `MM_SIZE;
  localparam int DW              = `MM_DWIDTH;
  localparam int MEM_WORDS       = 1 << `MM_AWIDTH;
  localparam int NUM_CASES       = 6;
  localparam int LATENCY         = 4 * N + 1;
  localparam int RESTART_AT      = 6;
  localparam int IDLE_CHECK      = 4;
  localparam int WATCHDOG_CYCLES = NUM_CASES * (4 * N + 10) + 20;

  typedef enum logic [1:0] {fill_identity, fill_ones, fill_max, fill_random} fill_t;

  typedef struct packed {
    matmul_pkg::matmul_cmd_t cmd;
    fill_t                   fill;
    logic                    restart;
  } case_t;

  logic                    clk;
  logic                    reset;
  logic                    start_mat_mul;
  matmul_pkg::matmul_cmd_t cmd;
  matmul_pkg::addr_t       a_addr;
  matmul_pkg::addr_t       b_addr;
  matmul_pkg::lane_vec_t   a_data = '0;
  matmul_pkg::lane_vec_t   b_data = '0;
  matmul_pkg::c_row_t      c_out;
  logic                    done_mat_mul;

  matmul_pkg::lane_vec_t a_mem [MEM_WORDS];
  matmul_pkg::lane_vec_t b_mem [MEM_WORDS];
  matmul_pkg::lane_vec_t exp_rows [N];
  case_t                 cases [NUM_CASES];

  // Filled by the monitor, never cleared
  matmul_pkg::addr_t     a_seen [$];
  matmul_pkg::addr_t     b_seen [$];
  matmul_pkg::addr_t     row_addrs [$];
  matmul_pkg::lane_vec_t row_datas [$];
  int                    done_count   = 0;
  int                    rows_at_done = 0;
  int                    errors;
  int                    chk_fails;

  matmul_top u_matmul_top (
    .clk          (clk),
    .reset        (reset),
    .start_mat_mul(start_mat_mul),
    .cmd          (cmd),
    .a_addr       (a_addr),
    .b_addr       (b_addr),
    .a_data       (a_data),
    .b_data       (b_data),
    .c_out        (c_out),
    .done_mat_mul (done_mat_mul)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Operand memories, word ready one cycle after its address
  always @(posedge clk) begin
    a_data <= a_mem[a_addr];
    b_data <= b_mem[b_addr];
  end

  always @(negedge clk) begin
    if (!reset) begin
      if (u_matmul_top.feed_en) begin
        a_seen.push_back(a_addr);
        b_seen.push_back(b_addr);
      end
      if (c_out.available) begin
        row_addrs.push_back(c_out.addr);
        row_datas.push_back(c_out.data);
      end
      if (done_mat_mul) begin
        done_count++;
        rows_at_done = row_addrs.size();
      end
    end
  end

  ////////////////////
  // Case table and reference model
  ////////////////////

  function automatic case_t make_case(
    input matmul_pkg::addr_t   aa, input matmul_pkg::addr_t   ab, input matmul_pkg::addr_t ac,
    input matmul_pkg::stride_t sa, input matmul_pkg::stride_t sb, input matmul_pkg::stride_t sc,
    input fill_t fill, input logic restart
  );
    case_t tc;
    tc.cmd.addr_a   = aa;
    tc.cmd.addr_b   = ab;
    tc.cmd.addr_c   = ac;
    tc.cmd.stride_a = sa;
    tc.cmd.stride_b = sb;
    tc.cmd.stride_c = sc;
    tc.fill         = fill;
    tc.restart      = restart;
    return tc;
  endfunction

  task automatic load_case_table();
    //                   addr_a   addr_b   addr_c   str_a     str_b  str_c     fill
    cases[0] = make_case(10'h000, 10'h100, 10'h200, 16'd1,    16'd1, 16'd1,    fill_identity, 1'b0);
    cases[1] = make_case(10'h010, 10'h120, 10'h210, 16'd3,    16'd5, 16'd2,    fill_random,   1'b0);
    cases[2] = make_case(10'h3fe, 10'h3fc, 10'h3fd, 16'd1,    16'd2, 16'd7,    fill_max,      1'b0);
    cases[3] = make_case(10'h040, 10'h080, 10'h0c0, 16'h0104, 16'd9, 16'h0400, fill_random,   1'b1);
    cases[4] = make_case(10'h0a0, 10'h0b0, 10'h3f0, 16'd4,    16'd4, 16'd8,    fill_ones,     1'b0);
    cases[5] = make_case(10'h020, 10'h200, 10'h100, 16'hffff, 16'd1, 16'd64,   fill_random,   1'b1);
  endtask

  // base + k * stride, wrapped to the address width
  function automatic matmul_pkg::addr_t step_addr(
    input matmul_pkg::addr_t base, input matmul_pkg::stride_t stride, input int k
  );
    return matmul_pkg::addr_t'(int'(base) + k * int'(stride));
  endfunction

  function automatic matmul_pkg::data_t element(
    input fill_t fill, input logic is_a, input int r, input int c
  );
    case (fill)
      fill_identity: begin
        if (is_a) begin
          return (r == c) ? matmul_pkg::data_t'(1) : matmul_pkg::data_t'(0);
        end
        return matmul_pkg::data_t'($urandom());
      end
      fill_ones: return matmul_pkg::data_t'(1);
      fill_max:  return '1;
      default:   return matmul_pkg::data_t'($urandom());
    endcase
  endfunction

  task automatic fill_memories(input case_t tc);
    matmul_pkg::lane_vec_t wa;
    matmul_pkg::lane_vec_t wb;
    // Background words so that a stray read shows up in the result
    for (int w = 0; w < MEM_WORDS; w++) begin
      a_mem[w] = matmul_pkg::lane_vec_t'(w * 32'h9e37_79b1);
      b_mem[w] = matmul_pkg::lane_vec_t'(w * 32'h85eb_ca6b) ^ 32'h5a5a_a5a5;
    end
    for (int k = 0; k < N; k++) begin
      wa = '0;
      wb = '0;
      for (int x = 0; x < N; x++) begin
        wa[x*DW +: DW] = element(tc.fill, 1'b1, x, k);
        wb[x*DW +: DW] = element(tc.fill, 1'b0, k, x);
      end
      a_mem[step_addr(tc.cmd.addr_a, tc.cmd.stride_a, k)] = wa;
      b_mem[step_addr(tc.cmd.addr_b, tc.cmd.stride_b, k)] = wb;
    end
  endtask

  task automatic build_expected(input case_t tc);
    matmul_pkg::lane_vec_t wa;
    matmul_pkg::lane_vec_t wb;
    int                    sum;
    int                    a_el [N][N];
    int                    b_el [N][N];
    for (int k = 0; k < N; k++) begin
      wa = a_mem[step_addr(tc.cmd.addr_a, tc.cmd.stride_a, k)];
      wb = b_mem[step_addr(tc.cmd.addr_b, tc.cmd.stride_b, k)];
      for (int x = 0; x < N; x++) begin
        a_el[x][k] = int'(wa[x*DW +: DW]);
        b_el[k][x] = int'(wb[x*DW +: DW]);
      end
    end
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        sum = 0;
        for (int k = 0; k < N; k++) begin
          sum += a_el[i][k] * b_el[k][j];
        end
        exp_rows[i][j*DW +: DW] = matmul_pkg::data_t'(sum);
      end
    end
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got == exp) else begin
      errors++;
      $display("error %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  ////////////////////
  // One run per table entry
  ////////////////////

  task automatic run_case(input int idx);
    case_t tc;
    int    cycles;
    int    row_base;
    int    seen_base;
    int    done_base;
    logic  got_done;
    tc = cases[idx];
    fill_memories(tc);
    build_expected(tc);
    row_base  = row_addrs.size();
    seen_base = a_seen.size();
    done_base = done_count;

    @(posedge clk);
    cmd           <= tc.cmd;
    start_mat_mul <= 1'b1;
    @(posedge clk);
    start_mat_mul <= 1'b0;
    cycles   = 1;
    got_done = 1'b0;
    while (!got_done) begin
      @(negedge clk);
      if (done_mat_mul) begin
        got_done = 1'b1;
      end else begin
        @(posedge clk);
        cycles++;
        // Second start in the middle of the run
        start_mat_mul <= tc.restart && (cycles == RESTART_AT);
      end
    end
    check_equal(cycles, LATENCY, $sformatf("case %0d done latency", idx));

    repeat (IDLE_CHECK) begin
      @(negedge clk);
      check_equal(c_out.available, 0, $sformatf("case %0d available after done", idx));
      check_equal(done_mat_mul, 0, $sformatf("case %0d extra done", idx));
    end

    check_equal(done_count - done_base, 1, $sformatf("case %0d done pulses", idx));
    check_equal(rows_at_done - row_base, N, $sformatf("case %0d rows before done", idx));
    check_equal(row_addrs.size() - row_base, N, $sformatf("case %0d row count", idx));
    check_equal(a_seen.size() - seen_base, N, $sformatf("case %0d feed cycles", idx));

    if (a_seen.size() - seen_base == N) begin
      for (int k = 0; k < N; k++) begin
        check_equal(a_seen[seen_base + k], step_addr(tc.cmd.addr_a, tc.cmd.stride_a, k),
                    $sformatf("case %0d a_addr step %0d", idx, k));
        check_equal(b_seen[seen_base + k], step_addr(tc.cmd.addr_b, tc.cmd.stride_b, k),
                    $sformatf("case %0d b_addr step %0d", idx, k));
      end
    end
    if (row_addrs.size() - row_base == N) begin
      for (int i = 0; i < N; i++) begin
        check_equal(row_addrs[row_base + i], step_addr(tc.cmd.addr_c, tc.cmd.stride_c, i),
                    $sformatf("case %0d row %0d addr", idx, i));
        check_equal(row_datas[row_base + i], exp_rows[i],
                    $sformatf("case %0d row %0d data", idx, i));
      end
    end
  endtask

  initial begin
    void'($urandom(18120));
    errors        = 0;
    reset         = 1'b1;
    start_mat_mul = 1'b0;
    cmd           = '0;
    load_case_table();
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // Outputs stay quiet until the first start
    repeat (5) begin
      @(negedge clk);
      check_equal(done_mat_mul, 0, "done before first start");
      check_equal(c_out.available, 0, "available before first start");
    end

    for (int c = 0; c < NUM_CASES; c++) begin
      run_case(c);
    end

    chk_fails = u_matmul_top.u_ctrl.u_checker.fail_count;
    $display("errors: %0d testbench checks, %0d assertions", errors, chk_fails);
    if (errors == 0 && chk_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* matmul_top.f */
+incdir+logic
logic/matmul_pkg.sv
logic/matmul_ctrl.sv
logic/operand_feeder.sv
logic/systolic_array.sv
logic/result_writer.sv
logic/matmul_top.sv
tests/matmul_checker.sv
tests/matmul_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module matmul_tb -f matmul_top.f

out=$(./obj_dir/Vmatmul_tb +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "Simulation PASSED"
